// ==== design/pllPkg.sv ====
`default_nettype none

package pllPkg;

    // Datapath widths
    localparam int freqWidth = 32;
    localparam int gainWidth = 5;
    localparam int divWidth  = 8;
    localparam int errWidth  = 8;

    // APB bus widths
    localparam int addrWidth = 8;
    localparam int dataWidth = 32;

    // Phase error saturation, symmetric around zero
    localparam logic signed [errWidth-1:0] errMax = 8'sh7F;
    localparam logic signed [errWidth-1:0] errMin = 8'sh81;

    // Positive clamp of the increment; negative clamp is zero
    localparam logic [freqWidth-1:0] incMax = 32'h7FFF_FFFF;

    // Gain code that adds the error unshifted
    localparam logic [gainWidth-1:0] gainUnity = 5'd7;

    // Register map
    localparam logic [addrWidth-1:0] addrCenterFreq  = 8'h00;
    localparam logic [addrWidth-1:0] addrLoopGain    = 8'h04;
    localparam logic [addrWidth-1:0] addrFeedbackDiv = 8'h08;
    localparam logic [addrWidth-1:0] addrPhaseError  = 8'h0C;

    // Register reset values
    localparam logic [freqWidth-1:0] centerResetValue = 32'h0800_0000;
    localparam logic [gainWidth-1:0] gainResetValue   = 5'd0;
    localparam logic [divWidth-1:0]  divResetValue    = 8'd1;

endpackage

`default_nettype wire

// ==== design/pllRegisters.sv ====
`timescale 1ns/1ps
`default_nettype none

module pllRegisters (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [pllPkg::addrWidth-1:0]  paddr,
    input  logic [pllPkg::dataWidth-1:0]  pwdata,
    input  logic [pllPkg::errWidth-1:0]   phaseError,
    output logic [pllPkg::dataWidth-1:0]  prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic [pllPkg::freqWidth-1:0]  centerFreq,
    output logic [pllPkg::gainWidth-1:0]  loopGain,
    output logic [pllPkg::divWidth-1:0]   feedbackDivider
);

    import pllPkg::*;

    logic                 access;
    logic                 mapped;
    logic                 writeOk;
    logic [divWidth-1:0]  divWrite;
    logic [dataWidth-1:0] errExtended;

    // Access phase of a transfer, no wait states
    assign access = psel & penable;
    assign pready = 1'b1;

    always_comb begin
        case (paddr)
            addrCenterFreq,
            addrLoopGain,
            addrFeedbackDiv,
            addrPhaseError: mapped = 1'b1;
            default:        mapped = 1'b0;
        endcase
    end

    // Phase error is read only
    assign pslverr = access && (!mapped || (pwrite && paddr == addrPhaseError));
    assign writeOk = access && pwrite && !pslverr;

    // Dividers never see zero
    assign divWrite = (pwdata[divWidth-1:0] == '0) ? divWidth'(1) : pwdata[divWidth-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            centerFreq      <= centerResetValue;
            loopGain        <= gainResetValue;
            feedbackDivider <= divResetValue;
        end
        else if (writeOk) begin
            case (paddr)
                addrCenterFreq:  centerFreq <= pwdata[freqWidth-1:0];
                addrLoopGain:    loopGain <= pwdata[gainWidth-1:0];
                addrFeedbackDiv: feedbackDivider <= divWrite;
                default:         ;
            endcase
        end
    end

    assign errExtended = {{(dataWidth-errWidth){phaseError[errWidth-1]}}, phaseError};

    // Read data only during a read access
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                addrCenterFreq:  prdata = dataWidth'(centerFreq);
                addrLoopGain:    prdata = dataWidth'(loopGain);
                addrFeedbackDiv: prdata = dataWidth'(feedbackDivider);
                addrPhaseError:  prdata = errExtended;
                default:         prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/phaseDetector.sv ====
`timescale 1ns/1ps
`default_nettype none

module phaseDetector (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                referenceClkEn,
    input  logic                                feedbackClkEn,
    output logic signed [pllPkg::errWidth-1:0]  phaseError
);

    import pllPkg::*;

    logic refOnly;
    logic fbOnly;

    // Coincident pulses cancel
    assign refOnly = referenceClkEn & ~feedbackClkEn;
    assign fbOnly  = feedbackClkEn & ~referenceClkEn;

    always_ff @(posedge clk) begin
        if (reset) begin
            phaseError <= '0;
        end
        else if (refOnly) begin
            // Reference ahead, count up
            if (phaseError < errMax) begin
                phaseError <= phaseError + 1'b1;
            end
        end
        else if (fbOnly) begin
            if (phaseError > errMin) begin
                phaseError <= phaseError - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/loopFilter.sv ====
`timescale 1ns/1ps
`default_nettype none

module loopFilter (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic signed [pllPkg::errWidth-1:0]   phaseError,
    input  logic        [pllPkg::gainWidth-1:0]  loopGain,
    input  logic        [pllPkg::freqWidth-1:0]  centerFreq,
    output logic        [pllPkg::freqWidth-1:0]  phaseInc
);

    import pllPkg::*;

    logic signed [freqWidth-1:0] errorWide;
    logic signed [freqWidth-1:0] scaled;
    logic signed [freqWidth-1:0] correction;
    logic signed [freqWidth+1:0] errorSum;

    assign errorWide = phaseError;

    // Power of two around the unity code
    always_comb begin
        // Code 0 turns the loop off
        if (loopGain == '0) begin
            scaled = '0;
        end
        else if (loopGain >= gainUnity) begin
            scaled = errorWide <<< (loopGain - gainUnity);
        end
        else begin
            scaled = errorWide >>> (gainUnity - loopGain);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            correction <= '0;
        end
        else begin
            correction <= scaled;
        end
    end

    // Two spare bits hold the true signed sum
    assign errorSum = $signed({2'b00, centerFreq}) + correction;

    // Clamp to the positive limit or to zero
    always_ff @(posedge clk) begin
        if (errorSum > $signed({2'b00, incMax})) begin
            phaseInc <= incMax;
        end
        else if (errorSum < 0) begin
            phaseInc <= '0;
        end
        else begin
            phaseInc <= errorSum[freqWidth-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== design/nco.sv ====
`timescale 1ns/1ps
`default_nettype none

module nco (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [pllPkg::freqWidth-1:0]  phaseInc,
    input  logic [pllPkg::divWidth-1:0]   feedbackDivider,
    output logic                          dllOutputClkEn,
    output logic                          feedbackClkEn,
    output logic                          filteredRefClk
);

    import pllPkg::*;

    logic [freqWidth-1:0] phase;
    logic [freqWidth-1:0] phaseSum;
    logic                 sumRise;
    logic                 msbDelayed;
    logic [divWidth-1:0]  feedbackCount;
    logic [divWidth-2:0]  halfDivider;
    logic [divWidth-2:0]  outputCount;
    logic                 outputToggle;

    assign phaseSum = phase + phaseInc;

    // phase holds last cycle's sum
    assign sumRise = phaseSum[freqWidth-1] & ~phase[freqWidth-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            phase          <= '0;
            msbDelayed     <= 1'b0;
            dllOutputClkEn <= 1'b0;
        end
        else begin
            phase          <= phaseSum;
            msbDelayed     <= phase[freqWidth-1];
            dllOutputClkEn <= phase[freqWidth-1] & ~msbDelayed;
        end
    end

    // Every feedbackDivider-th rising edge of the sum
    always_ff @(posedge clk) begin
        if (reset) begin
            feedbackCount <= feedbackDivider - 1'b1;
            feedbackClkEn <= 1'b0;
        end
        else begin
            feedbackClkEn <= sumRise && (feedbackCount == '0);
            if (sumRise) begin
                if (feedbackCount == '0) begin
                    feedbackCount <= feedbackDivider - 1'b1;
                end
                else begin
                    feedbackCount <= feedbackCount - 1'b1;
                end
            end
        end
    end

    assign halfDivider = feedbackDivider[divWidth-1:1];

    // Toggle every half-divider output pulses
    always_ff @(posedge clk) begin
        if (reset) begin
            outputCount  <= halfDivider - 1'b1;
            outputToggle <= 1'b0;
        end
        else if (dllOutputClkEn) begin
            if (outputCount == '0) begin
                outputCount  <= halfDivider - 1'b1;
                outputToggle <= ~outputToggle;
            end
            else begin
                outputCount <= outputCount - 1'b1;
            end
        end
    end

    // Divider of 1 has no half period
    assign filteredRefClk = (halfDivider == '0) ? dllOutputClkEn : outputToggle;

endmodule

`default_nettype wire

// ==== design/pllTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module pllTop (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [pllPkg::addrWidth-1:0]  paddr,
    input  logic [pllPkg::dataWidth-1:0]  pwdata,
    output logic [pllPkg::dataWidth-1:0]  prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  logic                          referenceClkEn,
    output logic                          dllOutputClkEn,
    output logic                          feedbackClkEn,
    output logic                          filteredRefClk
);

    import pllPkg::*;

    logic        [freqWidth-1:0] centerFreq;
    logic        [gainWidth-1:0] loopGain;
    logic        [divWidth-1:0]  feedbackDivider;
    logic signed [errWidth-1:0]  phaseError;
    logic        [freqWidth-1:0] phaseInc;

    pllRegisters registers_i (
        .clk             (clk),
        .reset           (reset),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .phaseError      (phaseError),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .centerFreq      (centerFreq),
        .loopGain        (loopGain),
        .feedbackDivider (feedbackDivider)
    );

    phaseDetector detector_i (
        .clk            (clk),
        .reset          (reset),
        .referenceClkEn (referenceClkEn),
        .feedbackClkEn  (feedbackClkEn),
        .phaseError     (phaseError)
    );

    loopFilter filter_i (
        .clk        (clk),
        .reset      (reset),
        .phaseError (phaseError),
        .loopGain   (loopGain),
        .centerFreq (centerFreq),
        .phaseInc   (phaseInc)
    );

    nco nco_i (
        .clk             (clk),
        .reset           (reset),
        .phaseInc        (phaseInc),
        .feedbackDivider (feedbackDivider),
        .dllOutputClkEn  (dllOutputClkEn),
        .feedbackClkEn   (feedbackClkEn),
        .filteredRefClk  (filteredRefClk)
    );

endmodule

`default_nettype wire

// ==== testbench/pllChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module pllChecker (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [pllPkg::addrWidth-1:0]  paddr,
    input  logic [pllPkg::dataWidth-1:0]  pwdata,
    input  logic [pllPkg::dataWidth-1:0]  prdata,
    input  logic                          pready,
    input  logic                          pslverr,
    input  logic                          referenceClkEn,
    input  logic                          dllOutputClkEn,
    input  logic                          feedbackClkEn,
    input  logic                          filteredRefClk,
    input  logic                          window,
    input  int                            testMode,
    output int                            testsRun,
    output int                            testsFailed,
    output int                            errorCount
);

    import pllPkg::*;

    logic [freqWidth-1:0] centerModel;
    logic [gainWidth-1:0] gainModel;
    logic [divWidth-1:0]  divModel;
    int                   errorModel;
    int                   lastError;
    int                   errorsBefore;
    int                   cycles;
    int                   dllCount;
    int                   fbCount;
    int                   refCount;
    int                   toggles;
    bit                   windowDelayed;
    bit                   levelDelayed;
    string                names [7] = '{"", "register access", "open-loop frequency",
                                        "division", "saturation high", "saturation low",
                                        "closed-loop lock"};

    // Expected increment from gain shift and clamp
    function automatic longint expectedInc(logic [31:0] center, logic [4:0] gain, int err);
        longint corr;
        longint sum;
        if (gain == 0)
            corr = 0;
        else if (gain >= gainUnity)
            corr = longint'(err) <<< (gain - gainUnity);
        else
            corr = longint'(err) >>> (gainUnity - gain);
        sum = longint'(center) + corr;
        if (sum > longint'(incMax))
            return longint'(incMax);
        if (sum < 0)
            return 0;
        return sum;
    endfunction

    // Bit 31 rising edges of an accumulator started at zero
    function automatic int expectedRises(longint inc, int n);
        logic [31:0] acc;
        logic [31:0] next;
        int          rises;
        acc   = '0;
        rises = 0;
        for (int i = 0; i < n; i++) begin
            next = acc + 32'(inc);
            if (next[31] && !acc[31])
                rises++;
            acc = next;
        end
        return rises;
    endfunction

    function automatic logic [31:0] expectedRead(logic [7:0] addr);
        case (addr)
            addrCenterFreq:  return centerModel;
            addrLoopGain:    return 32'(gainModel);
            addrFeedbackDiv: return 32'(divModel);
            addrPhaseError:  return 32'(errorModel);
            default:         return '0;
        endcase
    endfunction

    task automatic mismatch(input string msg);
        $display("Mismatch at time %0t: %s", $time, msg);
        errorCount++;
    endtask

    task automatic checkAccess();
        logic bad;
        bad = !(paddr inside {addrCenterFreq, addrLoopGain, addrFeedbackDiv, addrPhaseError})
            || (pwrite && paddr == addrPhaseError);
        if (pslverr !== bad || pready !== 1'b1)
            mismatch($sformatf("pslverr %b pready %b at address %h", pslverr, pready, paddr));
        if (!pwrite && prdata !== expectedRead(paddr))
            mismatch($sformatf("read %h at address %h, expected %h", prdata, paddr,
                               expectedRead(paddr)));
        if (!pwrite && paddr == addrPhaseError) begin
            lastError = $signed(prdata);
            if (lastError > int'(errMax) || lastError < int'(errMin))
                mismatch($sformatf("phase error %0d outside saturation limits", lastError));
        end
        if (pwrite && !bad) begin
            case (paddr)
                addrCenterFreq:  centerModel = pwdata;
                addrLoopGain:    gainModel = pwdata[gainWidth-1:0];
                addrFeedbackDiv: divModel = (pwdata[7:0] == 8'd0) ? 8'd1 : pwdata[7:0];
                default:         ;
            endcase
        end
    endtask

    task automatic finishTest();
        int expected;
        int half;
        case (testMode)
            2: begin
                expected = expectedRises(expectedInc(centerModel, gainModel, errorModel), cycles);
                if (dllCount < expected - 1 || dllCount > expected + 1)
                    mismatch($sformatf("%0d output pulses, expected %0d", dllCount, expected));
            end
            3: begin
                expected = dllCount / int'(divModel);
                if (fbCount < expected - 1 || fbCount > expected + 1)
                    mismatch($sformatf("%0d feedback pulses, expected %0d", fbCount, expected));
                half = int'(divModel) / 2;
                if (half > 0 && (toggles < dllCount / half - 1 || toggles > dllCount / half + 1))
                    mismatch($sformatf("%0d toggles, expected %0d", toggles, dllCount / half));
            end
            4: if (lastError != int'(errMax))
                mismatch($sformatf("phase error %0d, expected %0d", lastError, int'(errMax)));
            5: if (lastError != int'(errMin))
                mismatch($sformatf("phase error %0d, expected %0d", lastError, int'(errMin)));
            6: if (fbCount < refCount - 2 || fbCount > refCount + 2)
                mismatch($sformatf("%0d feedback pulses against %0d reference", fbCount, refCount));
            default: ;
        endcase
        testsRun++;
        if (errorCount > errorsBefore)
            testsFailed++;
        $display("Test %0d %s: %s", testsRun, names[testMode],
                 (errorCount > errorsBefore) ? "failed" : "passed");
        errorsBefore = errorCount;
    endtask

    // Sampled mid-cycle, away from both edges
    always @(negedge clk) begin
        if (window && !windowDelayed) begin
            cycles    = 0;
            dllCount  = 0;
            fbCount   = 0;
            refCount  = 0;
            toggles   = 0;
            lastError = 0;
        end
        if (reset) begin
            centerModel = centerResetValue;
            gainModel   = gainResetValue;
            divModel    = divResetValue;
            errorModel  = 0;
        end
        else begin
            if (psel && penable)
                checkAccess();
            // Detector model, applied at the next rising edge
            if (referenceClkEn && !feedbackClkEn && errorModel < int'(errMax))
                errorModel++;
            else if (feedbackClkEn && !referenceClkEn && errorModel > int'(errMin))
                errorModel--;
        end
        if (window) begin
            cycles++;
            dllCount += int'(dllOutputClkEn);
            fbCount  += int'(feedbackClkEn);
            refCount += int'(referenceClkEn);
            toggles  += int'(filteredRefClk != levelDelayed);
            if (testMode == 3 && divModel == 8'd1 && filteredRefClk !== dllOutputClkEn)
                mismatch("filteredRefClk differs from dllOutputClkEn with divider 1");
        end
        if (windowDelayed && !window)
            finishTest();
        windowDelayed = window;
        levelDelayed  = filteredRefClk;
    end

endmodule

`default_nettype wire

// ==== testbench/pllTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pllTb;

    import pllPkg::*;

    localparam int clkPeriod    = 100;
    localparam int openWindow   = 2000;
    // Drains a stale divider count at 16 cycles per output edge
    localparam int settleCycles = 4200;
    localparam int satCycles    = 1600;
    localparam int lockSettle   = 32000;
    localparam int lockWindow   = 4096;
    localparam int lockPeriod   = 64;
    localparam int testCount    = 9;
    localparam int budgetCycles = 5 * openWindow + 4 * settleCycles + 2 * satCycles
                                + lockSettle + lockWindow + 2000;

    logic                 clk;
    logic                 reset;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [addrWidth-1:0] paddr;
    logic [dataWidth-1:0] pwdata;
    logic [dataWidth-1:0] prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 referenceClkEn;
    logic                 dllOutputClkEn;
    logic                 feedbackClkEn;
    logic                 filteredRefClk;
    logic                 window = 1'b0;
    int                   testMode = 0;
    int                   refPeriod = 0;
    int                   testsRun;
    int                   testsFailed;
    int                   errorCount;
    logic [31:0]          lcgState = 32'd23;

    pllTop dut_i (.*);

    pllChecker checker_i (.*);

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic apbAccess(input logic write, input logic [addrWidth-1:0] addr,
                             input logic [dataWidth-1:0] data);
        psel   = 1'b1;
        pwrite = write;
        paddr  = addr;
        pwdata = data;
        step(1);
        penable = 1'b1;
        @(posedge clk);
        while (!pready)
            @(posedge clk);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic closeTest();
        window = 1'b0;
        step(2);
    endtask

    task automatic runWindow(input int n);
        window = 1'b1;
        step(n);
        closeTest();
    endtask

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Reference pulse train with one pulse every refPeriod cycles
    initial begin
        int gap;
        gap            = 0;
        referenceClkEn = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            if (refPeriod > 0 && gap == 0) begin
                referenceClkEn = 1'b1;
                gap            = refPeriod - 1;
            end
            else begin
                referenceClkEn = 1'b0;
                if (gap > 0)
                    gap--;
            end
        end
    end

    initial begin
        #(budgetCycles * clkPeriod);
        $display("Timeout: the tests did not finish within %0d cycles", budgetCycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        step(4);
        reset = 1'b0;

        testMode = 1;
        window   = 1'b1;
        apbAccess(1'b1, addrCenterFreq, nextRandom());
        apbAccess(1'b1, addrLoopGain, nextRandom());
        apbAccess(1'b1, addrFeedbackDiv, 32'h0);
        for (int i = 0; i < 4; i++)
            apbAccess(1'b0, 8'(i * 4), '0);
        // Bad accesses leave the registers alone
        apbAccess(1'b1, 8'h10, '1);
        apbAccess(1'b0, 8'h3C, '0);
        apbAccess(1'b1, addrPhaseError, '1);
        for (int i = 0; i < 4; i++)
            apbAccess(1'b0, 8'(i * 4), '0);
        apbAccess(1'b1, addrFeedbackDiv, nextRandom());
        apbAccess(1'b0, addrFeedbackDiv, '0);
        closeTest();

        testMode = 2;
        apbAccess(1'b1, addrLoopGain, 32'h0);
        apbAccess(1'b1, addrCenterFreq, 32'h0100_0000 + (nextRandom() & 32'h1FFF_FFFF));
        step(10);
        runWindow(openWindow);

        testMode = 3;
        apbAccess(1'b1, addrCenterFreq, 32'h1000_0000);
        for (int i = 0; i < 4; i++) begin
            apbAccess(1'b1, addrFeedbackDiv, (i == 3) ? 32'd1 : 32'd2 + (nextRandom() >> 16) % 14);
            step(settleCycles);
            runWindow(openWindow);
        end

        // NCO stopped and reference alone
        testMode = 4;
        window   = 1'b1;
        apbAccess(1'b1, addrCenterFreq, 32'h0);
        refPeriod = 1 + int'((nextRandom() >> 16) % 3);
        step(satCycles);
        refPeriod = 0;
        step(2);
        apbAccess(1'b0, addrPhaseError, '0);
        closeTest();

        testMode = 5;
        window   = 1'b1;
        apbAccess(1'b1, addrFeedbackDiv, 32'd1);
        apbAccess(1'b1, addrCenterFreq, 32'h4000_0000);
        step(satCycles);
        apbAccess(1'b0, addrPhaseError, '0);
        closeTest();

        testMode = 6;
        apbAccess(1'b1, addrFeedbackDiv, 32'd4);
        apbAccess(1'b1, addrCenterFreq, 32'h0F00_0000 + (nextRandom() >> 8) % 32'h0200_0000);
        apbAccess(1'b1, addrLoopGain, 32'd29);
        refPeriod = lockPeriod;
        repeat (8) begin
            step(lockSettle / 8);
            apbAccess(1'b0, addrPhaseError, '0);
        end
        runWindow(lockWindow);
        refPeriod = 0;
        step(2);

        $display("Tests run %0d, failed %0d, mismatches %0d", testsRun, testsFailed, errorCount);
        if (testsRun != testCount)
            $display("Only %0d of %0d tests reported a result", testsRun, testCount);
        if (testsRun == testCount && testsFailed == 0 && errorCount == 0) begin
            $display("=== PASS ===");
        end
        else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
design/pllPkg.sv
design/pllRegisters.sv
design/phaseDetector.sv
design/loopFilter.sv
design/nco.sv
design/pllTop.sv
testbench/pllChecker.sv
testbench/pllTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the PLL testbench with Verilator, then look for the pass line in the log
rm -f sim.log
rm -rf obj_dir \
    && verilator --binary --timing -Wno-fatal -f tb.f --top-module pllTb -o pllSim \
    && ./obj_dir/pllSim | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }
grep -qx "=== PASS ===" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
